/* hdl/riscPkg.sv */
`default_nettype none

package riscPkg;

	// ------------------
	// Word layout
	// ------------------
	localparam int WordWidth = 12;                 // Data, instruction and address width
	localparam logic [7:0] PortPageTag = 8'hFF;    // Upper address byte selecting the ports

	typedef logic [WordWidth-1:0] wordT;           // Machine word
	typedef logic [2:0] regIdxT;                   // One of eight registers

	// ------------------
	// Instruction codes
	// ------------------
	// Opcode in IR[11:6] with Ri and Rj below it
	typedef enum logic [5:0]
	{
		LD_IC   = 6'b000000,    // R[Ri] <- port(R[Rj])
		ST_IC   = 6'b000001,    // port(R[Rj]) <- R[Ri]
		JMP_IC  = 6'b000100,    // PC <- R[Rj] when condition holds
		ADD_IC  = 6'b100000,
		SUB_IC  = 6'b100001,
		ADDC_IC = 6'b100010,    // Immediate in the Rj field
		SUBC_IC = 6'b100011,
		NOT_IC  = 6'b101000,
		AND_IC  = 6'b101001,
		OR_IC   = 6'b101010,
		XOR_IC  = 6'b101011,
		SHLL_IC = 6'b101100,    // Shift amount is the Rj field
		SHRL_IC = 6'b101101,
		SHRA_IC = 6'b101111,
		ROTL_IC = 6'b110000,
		ROTR_IC = 6'b110001
	} opcodeT;

	// Jump condition carried in the Ri field
	typedef enum logic [2:0]
	{
		JU  = 3'd0,             // Always
		JC1 = 3'd1,
		JN1 = 3'd2,
		JV1 = 3'd3,
		JZ1 = 3'd4,
		JC0 = 3'd5,
		JN0 = 3'd6,
		JZ0 = 3'd7              // No room left for JV0
	} jumpCondT;

	// ------------------
	// Status and sequencing
	// ------------------
	typedef struct packed
	{
		logic carry;            // Borrow on subtract
		logic negative;
		logic overflow;
		logic zero;
	} flagsT;

	typedef enum logic [1:0] {MC0, MC1, MC2, MC3} machineCycleT;

endpackage

`default_nettype wire

/* hdl/cpuIfs.sv */
`default_nettype none

// ------------------
// Fetch to execute
// ------------------
interface issueIf
	import riscPkg::*;
();
	logic issue;            // High for the MC1 cycle only
	wordT instr;            // Held from MC1 through MC3
	logic branchTaken;      // MC3 pulse from execute
	wordT branchTarget;     // New PC when branchTaken

	modport source
	(
		output issue, instr,
		input  branchTaken, branchTarget
	);

	modport sink
	(
		input  issue, instr,
		output branchTaken, branchTarget
	);
endinterface

// ------------------
// Execute to registers
// ------------------
interface regIf
	import riscPkg::*;
();
	regIdxT rdAddrA, rdAddrB;
	wordT   rdDataA, rdDataB;   // Combinational read data
	logic   wrEn;               // Write lands on the clock edge
	regIdxT wrAddr;
	wordT   wrData;

	modport master (output rdAddrA, rdAddrB, wrEn, wrAddr, wrData, input rdDataA, rdDataB);
	modport target (input rdAddrA, rdAddrB, wrEn, wrAddr, wrData, output rdDataA, rdDataB);
endinterface

`default_nettype wire

/* hdl/aluCore.sv */
`default_nettype none

module aluCore
	import riscPkg::*;
(
	input wire opcodeT opcode,
	input wire wordT   operandA,     // TA
	input wire wordT   operandB,     // TB from a register or the immediate
	input wire regIdxT shiftAmount,  // Rj field
	input wire flagsT  flagsIn,
	output wordT       result,
	output flagsT      flagsOut
);

	localparam int Msb = WordWidth - 1;    // Sign bit position

	logic [WordWidth:0]     sumExt, diffExt;        // Extra bit is carry or borrow
	logic [2*WordWidth-1:0] rotLeftExt, rotRightExt;

	assign sumExt  = {1'b0, operandA} + {1'b0, operandB};
	assign diffExt = {1'b0, operandA} - {1'b0, operandB};

	// Doubled word makes rotates plain shifts
	assign rotLeftExt  = {operandA, operandA} << shiftAmount;
	assign rotRightExt = {operandA, operandA} >> shiftAmount;

	// ------------------
	// Result and flags
	// ------------------
	always_comb
	begin
		result   = '0;
		flagsOut = flagsIn;    // Default is no change
		case (opcode)
			ADD_IC, ADDC_IC:
			begin
				result            = sumExt[Msb:0];
				flagsOut.carry    = sumExt[WordWidth];
				// Same-sign operands with the result sign flipped
				flagsOut.overflow = (operandA[Msb] == operandB[Msb]) &&
				                    (result[Msb] != operandA[Msb]);
			end
			SUB_IC, SUBC_IC:
			begin
				result            = diffExt[Msb:0];
				flagsOut.carry    = diffExt[WordWidth];    // Borrow
				flagsOut.overflow = (operandA[Msb] != operandB[Msb]) &&
				                    (result[Msb] != operandA[Msb]);
			end
			NOT_IC:  result = ~operandA;
			AND_IC:  result = operandA & operandB;
			OR_IC:   result = operandA | operandB;
			XOR_IC:  result = operandA ^ operandB;
			SHLL_IC: result = operandA << shiftAmount;
			SHRL_IC: result = operandA >> shiftAmount;
			SHRA_IC: result = wordT'($signed(operandA) >>> shiftAmount);   // Sign fill
			ROTL_IC: result = rotLeftExt[2*WordWidth-1 -: WordWidth];
			ROTR_IC: result = rotRightExt[Msb:0];
			default: result = '0;
		endcase

		// N and Z for arithmetic and logic only
		case (opcode)
			ADD_IC, SUB_IC, ADDC_IC, SUBC_IC, AND_IC, OR_IC, XOR_IC:
			begin
				flagsOut.negative = result[Msb];
				flagsOut.zero     = (result == '0);
			end
			default: ;     // NOT, shifts and rotates keep flags
		endcase
	end

endmodule

`default_nettype wire

/* hdl/registerFile.sv */
`default_nettype none

module registerFile
	import riscPkg::*;
(
	input wire logic Clock_pin,
	input wire logic reset,
	regIf.target     regs
);

	wordT regArray [8];     // R0..R7 all general purpose

	// ------------------
	// Write port
	// ------------------
	always_ff @(posedge Clock_pin)
	begin
		if (reset)
		begin
			for (int i = 0; i < 8; i++)
				regArray[i] <= '0;
		end
		else if (regs.wrEn)
		begin
			regArray[regs.wrAddr] <= regs.wrData;  // Single write in MC3
		end
	end

	// ------------------
	// Read ports
	// ------------------
	// Asynchronous reads
	// A write shows up the cycle after
	assign regs.rdDataA = regArray[regs.rdAddrA];
	assign regs.rdDataB = regArray[regs.rdAddrB];

endmodule

`default_nettype wire

/* hdl/instrFetch.sv */
`default_nettype none

module instrFetch
	import riscPkg::*;
#(
	parameter int ProgAddrWidth = 6     // Program memory depth is 2**ProgAddrWidth
)
(
	input wire logic                     Clock_pin,
	input wire logic                     reset,
	input wire logic                     progWrite,   // Loader strobe that also works in reset
	input wire logic [ProgAddrWidth-1:0] progAddr,
	input wire wordT                     progData,
	issueIf.source                       issue
);

	// ------------------
	// Storage
	// ------------------
	wordT progMem [2**ProgAddrWidth];   // Program store
	wordT progCounter;                  // Full word with upper bits ignored for fetch
	wordT instrReg;                     // IR
	machineCycleT machineCycle;         // MC0..MC3 sequencer

	logic [ProgAddrWidth-1:0] fetchAddr;

	assign fetchAddr = progCounter[ProgAddrWidth-1:0];    // Truncate PC to memory size

	// Loader port
	always_ff @(posedge Clock_pin)
	begin
		if (progWrite)
			progMem[progAddr] <= progData;
	end

	// Fetch into IR on MC0
	always_ff @(posedge Clock_pin)
	begin
		if (machineCycle == MC0)
			instrReg <= progMem[fetchAddr];
	end

	// ------------------
	// Sequencer
	// ------------------
	always_ff @(posedge Clock_pin)
	begin
		if (reset)
		begin
			progCounter  <= '0;
			machineCycle <= MC0;
		end
		else
		begin
			case (machineCycle)
				MC0:
				begin
					progCounter  <= progCounter + 1'b1;    // Point at the next word
					machineCycle <= MC1;
				end
				MC1: machineCycle <= MC2;              // Operands latched in execute
				MC2: machineCycle <= MC3;              // ALU result latched in execute
				MC3:
				begin
					// Taken jump overrides the incremented PC
					if (issue.branchTaken)
						progCounter <= issue.branchTarget;
					machineCycle <= MC0;
				end
				default: machineCycle <= MC0;
			endcase
		end
	end

	assign issue.issue = (machineCycle == MC1);  // One cycle per instruction
	assign issue.instr = instrReg;               // Stable until the next MC0 edge

endmodule

`default_nettype wire

/* hdl/execUnit.sv */
`default_nettype none

module execUnit
	import riscPkg::*;
(
	input wire logic       Clock_pin,
	input wire logic       reset,
	input wire logic [4:0] SW_pin,        // Switches read through the port page
	output logic [7:0]     Display_pin,   // LEDs written through the port page
	issueIf.sink           issue,
	regIf.master           regs
);

	machineCycleT stage;            // Idle in MC0 then MC2 and MC3 after issue
	opcodeT issueOp, opReg;         // Decoded at issue and held for MC2/MC3
	regIdxT riField, rjField;
	wordT opA, opB;                 // TA and TB
	wordT resultReg, aluResult;     // TALU
	flagsT flags, pendFlags, aluFlags;
	logic aluOp, portHit, condMet;
	wordT loadData;

	// Fields stay valid until the next fetch
	assign riField = issue.instr[5:3];
	assign rjField = issue.instr[2:0];
	assign issueOp = opcodeT'(issue.instr[11:6]);

	assign regs.rdAddrA = riField;  // Ri value or store data
	assign regs.rdAddrB = rjField;  // Rj value, port address or jump target

	aluCore aluCore_i
	(
		.opcode      (opReg),
		.operandA    (opA),
		.operandB    (opB),
		.shiftAmount (rjField),
		.flagsIn     (flags),
		.result      (aluResult),
		.flagsOut    (aluFlags)
	);

	// ------------------
	// Stage tracking
	// ------------------
	always_ff @(posedge Clock_pin)
	begin
		if (reset)
			stage <= MC0;
		else
		begin
			case (stage)
				MC0: if (issue.issue) stage <= MC2;   // MC1 is the issue cycle itself
				MC2: stage <= MC3;
				default: stage <= MC0;                // MC3 retires the instruction
			endcase
		end
	end

	// Operand and result registers
	always_ff @(posedge Clock_pin)
	begin
		if (issue.issue)
		begin
			opReg <= issueOp;
			opA   <= regs.rdDataA;
			if (issueOp == ADDC_IC || issueOp == SUBC_IC)
				opB <= {{(WordWidth-3){1'b0}}, rjField};     // 3-bit immediate
			else
				opB <= regs.rdDataB;
		end
		if (stage == MC2)
		begin
			resultReg <= aluResult;
			pendFlags <= aluFlags;
		end
	end

	// ------------------
	// MC3 decisions
	// ------------------
	always_comb
	begin
		case (opReg)
			ADD_IC, SUB_IC, ADDC_IC, SUBC_IC, NOT_IC, AND_IC, OR_IC, XOR_IC,
			SHLL_IC, SHRL_IC, SHRA_IC, ROTL_IC, ROTR_IC: aluOp = 1'b1;
			default:                                      aluOp = 1'b0;
		endcase
	end

	assign portHit  = (opB[WordWidth-1 -: 8] == PortPageTag);   // Any 12'hFFx address
	assign loadData = portHit ? {{(WordWidth-5){1'b0}}, SW_pin} : '0;

	// Condition check against the current status register
	always_comb
	begin
		case (jumpCondT'(riField))
			JU:      condMet = 1'b1;
			JC1:     condMet = flags.carry;
			JN1:     condMet = flags.negative;
			JV1:     condMet = flags.overflow;
			JZ1:     condMet = flags.zero;
			JC0:     condMet = ~flags.carry;
			JN0:     condMet = ~flags.negative;
			default: condMet = ~flags.zero;       // JZ0
		endcase
	end

	assign regs.wrEn   = (stage == MC3) && (aluOp || opReg == LD_IC);
	assign regs.wrAddr = riField;
	assign regs.wrData = (opReg == LD_IC) ? loadData : resultReg;

	assign issue.branchTaken  = (stage == MC3) && (opReg == JMP_IC) && condMet;
	assign issue.branchTarget = opB;

	// Status register and LEDs
	always_ff @(posedge Clock_pin)
	begin
		if (reset)
		begin
			flags       <= '0;
			Display_pin <= '0;
		end
		else if (stage == MC3)
		begin
			if (aluOp)
				flags <= pendFlags;              // Unchanged bits already passed through
			if (opReg == ST_IC && portHit)
				Display_pin <= opA[7:0];         // Low byte of R[Ri]
		end
	end

endmodule

`default_nettype wire

/* hdl/riscTop.sv */
`default_nettype none

module riscTop
	import riscPkg::*;
#(
	parameter int ProgAddrWidth = 6     // Program memory address bits
)
(
	input wire logic                     Clock_pin,
	input wire logic                     reset,
	input wire logic [4:0]               SW_pin,
	input wire logic                     progWrite,   // Program load strobe
	input wire logic [ProgAddrWidth-1:0] progAddr,
	input wire wordT                     progData,
	output wire logic [7:0]              Display_pin
);

	// ------------------
	// Internal buses
	// ------------------
	issueIf issueBus ();    // Fetch to execute
	regIf   regBus ();      // Execute to register file

	instrFetch
	#(
		.ProgAddrWidth (ProgAddrWidth)
	)
	instrFetch_i
	(
		.Clock_pin (Clock_pin),
		.reset     (reset),
		.progWrite (progWrite),
		.progAddr  (progAddr),
		.progData  (progData),
		.issue     (issueBus.source)
	);

	registerFile registerFile_i
	(
		.Clock_pin (Clock_pin),
		.reset     (reset),
		.regs      (regBus.target)
	);

	execUnit execUnit_i
	(
		.Clock_pin   (Clock_pin),
		.reset       (reset),
		.SW_pin      (SW_pin),
		.Display_pin (Display_pin),    // LED register lives in execute
		.issue       (issueBus.sink),
		.regs        (regBus.master)
	);

endmodule

`default_nettype wire

/* testbench/riscCore_checker.sv */
`default_nettype none

module riscCore_checker
	import riscPkg::*;
(
	input wire logic         Clock_pin,
	input wire logic         reset,
	input wire logic         issueStrobe,    // issueIf strobe in MC1 only
	input wire logic         wrEn,           // Register file write enable
	input wire machineCycleT machineCycle,   // Fetch sequencer state
	input wire logic [7:0]   Display_pin
);

	int assertFails = 0;    // Failed assertion tally

	// ------------------
	// Sequencing
	// ------------------
	// Four cycles per instruction with no stalls
	issueCadence: assert property (@(posedge Clock_pin) disable iff (reset)
		issueStrobe |=> !issueStrobe [*3] ##1 issueStrobe)
	else
	begin
		assertFails++;
		$error("issue strobe not spaced four cycles apart");
	end

	// Register writes land only at the end of MC3
	writeInMc3: assert property (@(posedge Clock_pin) disable iff (reset)
		wrEn |-> machineCycle == MC3)
	else
	begin
		assertFails++;
		$error("register write enable high outside MC3");
	end

	// LEDs move only on the edge that closes MC3
	displayAfterMc3: assert property (@(posedge Clock_pin) disable iff (reset)
		!$stable(Display_pin) |-> $past(machineCycle) == MC3)
	else
	begin
		assertFails++;
		$error("display changed outside the cycle after MC3");
	end

endmodule

// Bound at the top level to see fetch and execute together
bind riscTop riscCore_checker coreChecker_i
(
	.Clock_pin    (Clock_pin),
	.reset        (reset),
	.issueStrobe  (issueBus.issue),
	.wrEn         (regBus.wrEn),
	.machineCycle (instrFetch_i.machineCycle),
	.Display_pin  (Display_pin)
);

`default_nettype wire

/* testbench/riscTb.sv */
`default_nettype none

module riscTb
	import riscPkg::*;
();

	localparam int ProgAddrWidth = 6;
	localparam int HalfPeriod    = 4;     // 8-unit clock period
	localparam int NumTests      = 9;
	localparam int MaxWords      = 16;
	localparam int SlackInstr    = 8;     // Load and reset time per test in instruction slots

	logic                     Clock_pin;
	logic                     reset;
	logic [4:0]               SW_pin;
	logic                     progWrite;
	logic [ProgAddrWidth-1:0] progAddr;
	wordT                     progData;
	wire logic [7:0]          Display_pin;

	// ------------------
	// Stimulus table
	// ------------------
	string      testName [NumTests];
	wordT       progTab [NumTests][MaxWords];
	int         progLen [NumTests];       // Words to load
	int         instrCount [NumTests];    // Instructions actually executed
	logic [4:0] swTab [NumTests];
	logic [7:0] expTab [NumTests];        // Expected LED byte

	int   curTest    = -1;
	int   totalInstr = 0;
	int   errorCount = 0;
	int   checkCount = 0;
	logic tableReady = 1'b0;

	riscTop #(.ProgAddrWidth (ProgAddrWidth)) riscTop_i
	(
		.Clock_pin   (Clock_pin),
		.reset       (reset),
		.SW_pin      (SW_pin),
		.progWrite   (progWrite),
		.progAddr    (progAddr),
		.progData    (progData),
		.Display_pin (Display_pin)
	);

	always #HalfPeriod Clock_pin = ~Clock_pin;

	task automatic addInstr(input opcodeT op, input regIdxT ri, input regIdxT rj);
		progTab[curTest][progLen[curTest]] = {op, ri, rj};    // Opcode, Ri, Rj
		progLen[curTest]++;
	endtask

	// Every program opens by putting 12'hFF0 into R1
	task automatic newTest(input string name, input int count, input logic [4:0] sw,
		input logic [7:0] expected);
		curTest++;
		testName[curTest]   = name;
		instrCount[curTest] = count;
		swTab[curTest]      = sw;
		expTab[curTest]     = expected;
		progLen[curTest]    = 0;
		totalInstr += count;
		addInstr(NOT_IC, 3'd1, 3'd0);     // R1 = FFF
		addInstr(SHLL_IC, 3'd1, 3'd4);    // R1 = FF0
	endtask

	task automatic buildTable();
		newTest("resetIdle", 2, 5'h1F, 8'h00);      // No ST so LEDs stay cleared
		newTest("ldStSwitch", 4, 5'h15, 8'h15);
		addInstr(LD_IC, 3'd2, 3'd1);                // R2 = 015 from zero-extended switches
		addInstr(ST_IC, 3'd2, 3'd1);
		newTest("arithWrap", 8, 5'h1B, 8'h1D);
		addInstr(LD_IC, 3'd2, 3'd1);                // 01B
		addInstr(ADD_IC, 3'd2, 3'd1);               // 01B + FF0 = 00B
		addInstr(ADDC_IC, 3'd2, 3'd7);              // 012
		addInstr(SUB_IC, 3'd2, 3'd1);               // 012 - FF0 = 022
		addInstr(SUBC_IC, 3'd2, 3'd5);              // 01D
		addInstr(ST_IC, 3'd2, 3'd1);
		newTest("logicOps", 9, 5'h1D, 8'hEC);
		addInstr(LD_IC, 3'd2, 3'd1);                // 01D
		addInstr(XOR_IC, 3'd2, 3'd1);               // FED
		addInstr(ADDC_IC, 3'd3, 3'd3);              // R3 = 003
		addInstr(OR_IC, 3'd2, 3'd3);                // FEF
		addInstr(NOT_IC, 3'd3, 3'd0);               // R3 = FFC
		addInstr(AND_IC, 3'd2, 3'd3);               // FEC
		addInstr(ST_IC, 3'd2, 3'd1);
		newTest("shiftRotate", 9, 5'h13, 8'hB8);
		addInstr(LD_IC, 3'd2, 3'd1);                // 013
		addInstr(ROTR_IC, 3'd2, 3'd2);              // C04 with low bits wrapped to the top
		addInstr(SHRA_IC, 3'd2, 3'd1);              // E02 with sign kept
		addInstr(SHRL_IC, 3'd2, 3'd1);              // 701
		addInstr(ROTL_IC, 3'd2, 3'd4);              // 017
		addInstr(SHLL_IC, 3'd2, 3'd3);              // 0B8
		addInstr(ST_IC, 3'd2, 3'd1);
		newTest("jumpZeroTaken", 9, 5'h00, 8'h09);
		addInstr(ADDC_IC, 3'd2, 3'd3);
		addInstr(ADDC_IC, 3'd3, 3'd3);
		addInstr(ADDC_IC, 3'd4, 3'd7);
		addInstr(ADDC_IC, 3'd4, 3'd2);              // Target 9
		addInstr(SUB_IC, 3'd2, 3'd3);               // Equal values set Z
		addInstr(JMP_IC, regIdxT'(JZ1), 3'd4);
		addInstr(ST_IC, 3'd3, 3'd1);                // Marker 03 is skipped
		addInstr(ST_IC, 3'd4, 3'd1);                // Marker 09 at word 9
		newTest("jumpCarryFall", 7, 5'h00, 8'hEF);
		addInstr(ADDC_IC, 3'd4, 3'd7);              // Target 7
		addInstr(NOT_IC, 3'd2, 3'd0);               // FFF
		addInstr(ADD_IC, 3'd2, 3'd1);               // FFF + FF0 = FEF with carry
		addInstr(JMP_IC, regIdxT'(JC0), 3'd4);      // Falls through
		addInstr(ST_IC, 3'd2, 3'd1);                // Marker EF
		addInstr(ST_IC, 3'd4, 3'd1);                // Marker 07 only if jumped
		newTest("jumpAlways", 5, 5'h00, 8'h05);
		addInstr(ADDC_IC, 3'd4, 3'd5);              // Target 5
		addInstr(JMP_IC, regIdxT'(JU), 3'd4);
		addInstr(ST_IC, 3'd1, 3'd1);                // Marker F0 is skipped
		addInstr(ST_IC, 3'd4, 3'd1);
		newTest("storeOffPage", 6, 5'h00, 8'h06);
		addInstr(ADDC_IC, 3'd2, 3'd6);
		addInstr(ST_IC, 3'd2, 3'd1);                // LEDs = 06
		addInstr(ADDC_IC, 3'd3, 3'd2);              // Address 002 is not a port
		addInstr(ST_IC, 3'd1, 3'd3);                // Dropped
		tableReady = 1'b1;
	endtask

	// ------------------
	// Checks and run
	// ------------------
	task automatic checkDisplay(input string name, input logic [7:0] expected,
		input logic [7:0] actual);
		checkCount++;
		if (actual !== expected)
		begin
			errorCount++;
			$display("Mismatch in %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	// Load under reset and then run the instruction budget
	task automatic runTest(input int t);
		@(posedge Clock_pin);
		#1;
		reset = 1'b1;
		for (int a = 0; a < progLen[t]; a++)
		begin
			progWrite = 1'b1;
			progAddr  = a[ProgAddrWidth-1:0];
			progData  = progTab[t][a];
			@(posedge Clock_pin);
			#1;
		end
		progWrite = 1'b0;
		SW_pin    = swTab[t];
		repeat (2) @(posedge Clock_pin);     // Reset held two more cycles
		#1;
		reset = 1'b0;
		repeat (instrCount[t] * 4 + 2) @(posedge Clock_pin);
		#1;                                   // LEDs settled after the edge
		checkDisplay(testName[t], expTab[t], Display_pin);
	endtask

	initial
	begin
		int assertFails;
		Clock_pin = 1'b0;
		reset     = 1'b1;
		SW_pin    = '0;
		progWrite = 1'b0;
		progAddr  = '0;
		progData  = '0;
		buildTable();
		for (int t = 0; t < NumTests; t++)
			runTest(t);
		assertFails = riscTop_i.coreChecker_i.assertFails;
		$display("Display checks: %0d, mismatches: %0d, assertion failures: %0d",
			checkCount, errorCount, assertFails);
		if (errorCount == 0 && assertFails == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

	// Watchdog sized from the table
	initial
	begin
		int limitCycles;
		wait (tableReady);
		limitCycles = (totalInstr + SlackInstr * NumTests) * 4;
		repeat (limitCycles) @(posedge Clock_pin);
		$display("Simulation timed out after %0d cycles", limitCycles);
		$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire

/* vlog.f */
hdl/riscPkg.sv
hdl/cpuIfs.sv
hdl/aluCore.sv
hdl/registerFile.sv
hdl/instrFetch.sv
hdl/execUnit.sv
hdl/riscTop.sv
testbench/riscCore_checker.sv
testbench/riscTb.sv
